// File: include/denise_macros.svh
/*
  Constants for the sprite and colour core. Register addresses are byte
  addresses; the bus carries them as word addresses (bits 8 to 1).
*/
`ifndef DENISE_MACROS_SVH
`define DENISE_MACROS_SVH

// Sprite and collision group counts
`define NUM_SPRITES     8
`define NUM_PAIRS       4

// Data path widths
`define HPOS_W          9
`define SPR_DATA_W      16
`define RGB_W           12
`define CLUT_IDX_W      5
`define CLUT_DEPTH      32

// Beam timing
`define SOL_HPOS        9'd32
`define HPOS_RESTART    9'd2

// ID register value (ECS)
`define DENISE_ID       16'hFFFC

// Register map
`define ADDR_CLXDAT     9'h00E
`define ADDR_STRHOR     9'h03C
`define ADDR_DENISEID   9'h07C
`define ADDR_CLXCON     9'h098
`define ADDR_SPR_BASE   9'h140
`define ADDR_COLOR_BASE 9'h180

`endif

// File: logic/denise_pkg.sv
/*
  Types exchanged between the blocks of the core.
  bus_cmd_t is one registered bus cycle, 25 bits wide.
*/
`default_nettype none

`include "denise_macros.svh"

package denise_pkg;

  // Decoded register operation
  typedef enum logic [3:0] {
    OP_NONE,
    OP_STRHOR,
    OP_CLXCON,
    OP_SPRPOS,
    OP_SPRCTL,
    OP_SPRDATA,
    OP_SPRDATB,
    OP_COLOR,
    OP_CLXDAT_RD,
    OP_ID_RD
  } reg_op_e;

  // One bus cycle after decoding
  typedef struct packed {
    reg_op_e     op;
    // Low word address bits, colour index
    logic [4:0]  idx;
    logic [15:0] data;
  } bus_cmd_t;

  // Sprite pixel, {DATB bit, DATA bit}, 0 is transparent
  typedef struct packed {
    logic [1:0] pix;
  } spr_pix_t;

  // One bit per sprite pair
  typedef logic [`NUM_PAIRS-1:0] clx_grp_t;

endpackage

`default_nettype wire

// File: logic/reg_decoder.sv
/*
  Register bus front end. The bus is sampled every clock, there is no strobe.
  Two register stages: a command is seen two edges after its address.
  Unmapped addresses decode to OP_NONE.
*/
`timescale 1ns/1ps
`default_nettype none

`include "denise_macros.svh"

module reg_decoder
  import denise_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [7:0]              rga,
  input  logic [15:0]             db_in,
  output bus_cmd_t                cmd,
  output logic [`NUM_SPRITES-1:0] spr_sel
);

  localparam logic [8:0] A_CLXDAT   = `ADDR_CLXDAT;
  localparam logic [8:0] A_STRHOR   = `ADDR_STRHOR;
  localparam logic [8:0] A_ID       = `ADDR_DENISEID;
  localparam logic [8:0] A_CLXCON   = `ADDR_CLXCON;
  localparam logic [8:0] A_SPR_BASE = `ADDR_SPR_BASE;
  localparam logic [8:0] A_COLOR    = `ADDR_COLOR_BASE;

  logic [7:0]              rga_q;
  logic [15:0]             db_q;
  reg_op_e                 op_next;
  logic [`NUM_SPRITES-1:0] sel_next;

  //////////////////////////////////////////////////////////////
  // Bus input register
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // Address 0 is unmapped
    if (reset) begin
      rga_q <= '0;
    end else begin
      rga_q <= rga;
    end
    db_q <= db_in;
  end

  //////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////

  always_comb begin
    op_next  = OP_NONE;
    sel_next = '0;
    if (rga_q == A_CLXDAT[8:1]) begin
      op_next = OP_CLXDAT_RD;
    end else if (rga_q == A_STRHOR[8:1]) begin
      op_next = OP_STRHOR;
    end else if (rga_q == A_ID[8:1]) begin
      op_next = OP_ID_RD;
    end else if (rga_q == A_CLXCON[8:1]) begin
      op_next = OP_CLXCON;
    end else if (rga_q[7:5] == A_SPR_BASE[8:6]) begin
      // Sprite block, four words per sprite
      case (rga_q[1:0])
        2'd0:    op_next = OP_SPRPOS;
        2'd1:    op_next = OP_SPRCTL;
        2'd2:    op_next = OP_SPRDATA;
        default: op_next = OP_SPRDATB;
      endcase
      sel_next[rga_q[4:2]] = 1'b1;
    end else if (rga_q[7:5] == A_COLOR[8:6]) begin
      op_next = OP_COLOR;
    end
  end

  // Command register
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd.op  <= OP_NONE;
      spr_sel <= '0;
    end else begin
      cmd.op  <= op_next;
      spr_sel <= sel_next;
    end
    cmd.idx  <= rga_q[4:0];
    cmd.data <= db_q;
  end

endmodule

`default_nettype wire

// File: logic/beam_counter.sv
/*
  Free-running horizontal beam counter, wraps 511 to 0.
  A STRHOR write restarts it at 2; no long lines.
*/
`timescale 1ns/1ps
`default_nettype none

`include "denise_macros.svh"

module beam_counter
  import denise_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  bus_cmd_t          cmd,
  output logic [`HPOS_W-1:0] hpos,
  output logic              line_start
);

  always_ff @(posedge clk) begin
    if (reset) begin
      hpos       <= '0;
      line_start <= 1'b0;
    end else begin
      // Sync strobe restarts the line
      if (cmd.op == OP_STRHOR) begin
        hpos <= `HPOS_RESTART;
      end else begin
        hpos <= hpos + 1'b1;
      end
      // Early start of line, one cycle after the match
      line_start <= (hpos == `SOL_HPOS);
    end
  end

endmodule

`default_nettype wire

// File: logic/sprite_channel.sv
/*
  One hardware sprite: 16 two-bit pixels from the start position, every
  line while armed. Data registers rotate, so they are intact after a run.
  No attached mode.
*/
`timescale 1ns/1ps
`default_nettype none

`include "denise_macros.svh"

module sprite_channel
  import denise_pkg::*;
#(
  parameter int SPR_NUM = 0
) (
  input  logic               clk,
  input  logic               reset,
  input  bus_cmd_t           cmd,
  input  logic               sel,
  input  logic [`HPOS_W-1:0] hpos,
  output spr_pix_t           pix
);

  logic [`HPOS_W-1:0]     start;
  logic                   armed;
  logic [`SPR_DATA_W-1:0] data_a;
  logic [`SPR_DATA_W-1:0] data_b;
  logic [3:0]             run_cnt;
  logic                   match;
  logic                   shift_en;

  assign match    = armed && (hpos == start);
  // Counter wraps to 0 after 16 steps
  assign shift_en = match || (run_cnt != 4'd0);

  //////////////////////////////////////////////////////////////
  // Control registers and run counter
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      start   <= '0;
      armed   <= 1'b0;
      run_cnt <= '0;
      pix     <= '0;
    end else begin
      if (sel && cmd.op == OP_SPRPOS) begin
        start[8:1] <= cmd.data[7:0];
      end
      // CTL disarms, DATA arms
      if (sel && cmd.op == OP_SPRCTL) begin
        start[0] <= cmd.data[0];
        armed    <= 1'b0;
      end else if (sel && cmd.op == OP_SPRDATA) begin
        armed <= 1'b1;
      end
      // A new match restarts the run
      if (match) begin
        run_cnt <= 4'd1;
      end else if (shift_en) begin
        run_cnt <= run_cnt + 1'b1;
      end
      // Stage 1 of the pixel pipeline
      if (shift_en) begin
        pix.pix <= {data_b[`SPR_DATA_W-1], data_a[`SPR_DATA_W-1]};
      end else begin
        pix.pix <= 2'b00;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // Data shifters
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // Bus write wins over the rotate
    if (sel && cmd.op == OP_SPRDATA) begin
      data_a <= cmd.data;
    end else if (shift_en) begin
      data_a <= {data_a[`SPR_DATA_W-2:0], data_a[`SPR_DATA_W-1]};
    end
    if (sel && cmd.op == OP_SPRDATB) begin
      data_b <= cmd.data;
    end else if (shift_en) begin
      data_b <= {data_b[`SPR_DATA_W-2:0], data_b[`SPR_DATA_W-1]};
    end
  end

endmodule

`default_nettype wire

// File: logic/sprite_priority.sv
/*
  Sprite to sprite priority and collision groups, stage 2 of the pipeline.
  Lowest pair wins; inside a pair the even sprite wins when non-zero.
  CLXCON keeps only ENSP (bits 15 to 12).
*/
`timescale 1ns/1ps
`default_nettype none

`include "denise_macros.svh"

module sprite_priority
  import denise_pkg::*;
(
  input  logic                               clk,
  input  logic                               reset,
  input  bus_cmd_t                           cmd,
  input  spr_pix_t [`NUM_SPRITES-1:0]        pix,
  output logic [`CLUT_IDX_W-1:0]             clut_idx,
  output clx_grp_t                           clx_grp
);

  logic [`NUM_PAIRS-1:0]  ensp;
  logic [`CLUT_IDX_W-1:0] idx_next;
  clx_grp_t               grp_next;

  // CLXCON, odd sprite collision enables
  always_ff @(posedge clk) begin
    if (reset) begin
      ensp <= '0;
    end else if (cmd.op == OP_CLXCON) begin
      ensp <= cmd.data[15:12];
    end
  end

  //////////////////////////////////////////////////////////////
  // Pair priority
  //////////////////////////////////////////////////////////////

  always_comb begin
    idx_next = '0;
    // Walk downwards so the lowest visible pair is kept
    for (int k = `NUM_PAIRS - 1; k >= 0; k--) begin
      if (pix[2*k].pix != 2'b00) begin
        idx_next = {1'b1, 2'(k), pix[2*k].pix};
      end else if (pix[2*k+1].pix != 2'b00) begin
        idx_next = {1'b1, 2'(k), pix[2*k+1].pix};
      end
    end
  end

  // Collision groups, odd sprite only with its ENSP bit
  always_comb begin
    grp_next = '0;
    for (int k = 0; k < `NUM_PAIRS; k++) begin
      grp_next[k] = (pix[2*k].pix != 2'b00) ||
                    ((pix[2*k+1].pix != 2'b00) && ensp[k]);
    end
  end

  // Stage 2 registers
  always_ff @(posedge clk) begin
    if (reset) begin
      clx_grp <= '0;
    end else begin
      clx_grp <= grp_next;
    end
    clut_idx <= idx_next;
  end

endmodule

`default_nettype wire

// File: logic/register_readback.sv
/*
  CLXDAT sprite collisions and the read data path.
  Bits 0 to 8 and 15 read as zero. A read clears CLXDAT on the same edge,
  so collisions of that cycle are lost.
*/
`timescale 1ns/1ps
`default_nettype none

`include "denise_macros.svh"

module register_readback
  import denise_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  bus_cmd_t    cmd,
  input  clx_grp_t    clx_grp,
  output logic [15:0] db_out,
  output logic        db_oen
);

  // CLXDAT bits 14 to 9
  logic [5:0] clx_q;
  logic [5:0] clx_new;

  // Group pairs, highest bit first
  assign clx_new = {clx_grp[2] & clx_grp[3],
                    clx_grp[1] & clx_grp[3],
                    clx_grp[1] & clx_grp[2],
                    clx_grp[0] & clx_grp[3],
                    clx_grp[0] & clx_grp[2],
                    clx_grp[0] & clx_grp[1]};

  //////////////////////////////////////////////////////////////
  // Collision accumulator
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      clx_q <= '0;
    end else if (cmd.op == OP_CLXDAT_RD) begin
      clx_q <= '0;
    end else begin
      clx_q <= clx_q | clx_new;
    end
  end

  // Read data, holds between reads
  always_ff @(posedge clk) begin
    if (cmd.op == OP_CLXDAT_RD) begin
      db_out <= {1'b0, clx_q, 9'b0};
    end else if (cmd.op == OP_ID_RD) begin
      db_out <= `DENISE_ID;
    end
  end

  // One-cycle output enable per read
  always_ff @(posedge clk) begin
    if (reset) begin
      db_oen <= 1'b0;
    end else begin
      db_oen <= (cmd.op == OP_CLXDAT_RD) || (cmd.op == OP_ID_RD);
    end
  end

endmodule

`default_nettype wire

// File: logic/color_output.sv
/*
  Colour table and RGB output, stages 3 and 4 of the pipeline.
  Table entries are not reset and must be written before use.
  sol marks the RGB of position 32.
*/
`timescale 1ns/1ps
`default_nettype none

`include "denise_macros.svh"

module color_output
  import denise_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  bus_cmd_t               cmd,
  input  logic [`CLUT_IDX_W-1:0] clut_idx,
  input  logic                   line_start,
  output logic [3:0]             red,
  output logic [3:0]             green,
  output logic [3:0]             blue,
  output logic                   sol
);

  logic [`RGB_W-1:0] clut_mem [`CLUT_DEPTH];
  logic [`RGB_W-1:0] clut_rd;
  logic [`RGB_W-1:0] rgb_q;
  logic [1:0]        sol_dly;

  // Bus write port, red in bits 11 to 8
  always_ff @(posedge clk) begin
    if (cmd.op == OP_COLOR) begin
      clut_mem[cmd.idx] <= cmd.data[`RGB_W-1:0];
    end
  end

  // Stage 3, registered table read
  always_ff @(posedge clk) begin
    clut_rd <= clut_mem[clut_idx];
  end

  //////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      rgb_q   <= '0;
      sol_dly <= '0;
      sol     <= 1'b0;
    end else begin
      rgb_q   <= clut_rd;
      // Three stages to line up with the pixel
      sol_dly <= {sol_dly[0], line_start};
      sol     <= sol_dly[1];
    end
  end

  assign red   = rgb_q[11:8];
  assign green = rgb_q[7:4];
  assign blue  = rgb_q[3:0];

endmodule

`default_nettype wire

// File: logic/denise_top.sv
/*
  Sprite and colour core, one low-resolution pixel per clk.
  Single clock domain, synchronous active-high reset.
  No bitplanes, blanking or vsync.
*/
`timescale 1ns/1ps
`default_nettype none

`include "denise_macros.svh"

module denise_top
  import denise_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic [7:0]  rga,
  input  logic [15:0] db_in,
  output logic [15:0] db_out,
  output logic        db_oen,
  output logic [3:0]  red,
  output logic [3:0]  green,
  output logic [3:0]  blue,
  output logic        sol
);

  bus_cmd_t                    cmd;
  logic [`NUM_SPRITES-1:0]     spr_sel;
  logic [`HPOS_W-1:0]          hpos;
  logic                        line_start;
  spr_pix_t [`NUM_SPRITES-1:0] spr_pix;
  logic [`CLUT_IDX_W-1:0]      clut_idx;
  clx_grp_t                    clx_grp;

  reg_decoder u_dec (
    .clk     (clk),
    .reset   (reset),
    .rga     (rga),
    .db_in   (db_in),
    .cmd     (cmd),
    .spr_sel (spr_sel)
  );

  beam_counter u_beam (
    .clk        (clk),
    .reset      (reset),
    .cmd        (cmd),
    .hpos       (hpos),
    .line_start (line_start)
  );

  // Eight sprite channels
  for (genvar i = 0; i < `NUM_SPRITES; i++) begin : g_spr
    sprite_channel #(
      .SPR_NUM (i)
    ) u_spr (
      .clk   (clk),
      .reset (reset),
      .cmd   (cmd),
      .sel   (spr_sel[i]),
      .hpos  (hpos),
      .pix   (spr_pix[i])
    );
  end

  sprite_priority u_prio (
    .clk      (clk),
    .reset    (reset),
    .cmd      (cmd),
    .pix      (spr_pix),
    .clut_idx (clut_idx),
    .clx_grp  (clx_grp)
  );

  register_readback u_rdbk (
    .clk     (clk),
    .reset   (reset),
    .cmd     (cmd),
    .clx_grp (clx_grp),
    .db_out  (db_out),
    .db_oen  (db_oen)
  );

  color_output u_color (
    .clk        (clk),
    .reset      (reset),
    .cmd        (cmd),
    .clut_idx   (clut_idx),
    .line_start (line_start),
    .red        (red),
    .green      (green),
    .blue       (blue),
    .sol        (sol)
  );

endmodule

`default_nettype wire

// File: dv/denise_tb.sv
/*
  Testbench for the sprite and colour core. The beam runs free after one
  STRHOR. Register changes go in the sprite-free gap at the end of each
  line, so every line after the first window is checked pixel by pixel.
*/
`timescale 1ns/1ps
`default_nettype none

`include "denise_macros.svh"

module denise_tb;

  localparam int LINE           = 512;
  localparam int TIMEOUT_CYCLES = 24 * LINE + 2000;
  // Cycles from a sol to the first access of the gap (hpos 497)
  localparam int GAP_DELAY      = 461;

  localparam logic [7:0] RGA_IDLE   = 8'h00;
  localparam logic [7:0] RGA_CLXDAT = 8'(`ADDR_CLXDAT >> 1);
  localparam logic [7:0] RGA_STRHOR = 8'(`ADDR_STRHOR >> 1);
  localparam logic [7:0] RGA_ID     = 8'(`ADDR_DENISEID >> 1);
  localparam logic [7:0] RGA_CLXCON = 8'(`ADDR_CLXCON >> 1);
  localparam logic [7:0] RGA_SPR    = 8'(`ADDR_SPR_BASE >> 1);
  localparam logic [7:0] RGA_COLOR  = 8'(`ADDR_COLOR_BASE >> 1);

  logic        clk;
  logic        reset;
  logic [7:0]  rga;
  logic [15:0] db_in;
  logic [15:0] db_out;
  logic        db_oen;
  logic [3:0]  red;
  logic [3:0]  green;
  logic [3:0]  blue;
  logic        sol;

  // Reference model state
  logic [8:0]  m_start [`NUM_SPRITES];
  logic        m_armed [`NUM_SPRITES];
  logic [15:0] m_da [`NUM_SPRITES];
  logic [15:0] m_db [`NUM_SPRITES];
  logic [11:0] m_clut [`CLUT_DEPTH];
  logic [3:0]  m_ensp;

  integer      seed;
  int          err_cnt   = 0;
  int          check_cnt = 0;
  int          cycle_cnt = 0;
  int          last_sol  = -1;
  bit          check_en  = 0;
  bit          busy      = 0;
  logic [11:0] exp_rgb [LINE];
  logic [15:0] exp_rd_q [$];
  int          exp_cyc_q [$];
  logic [15:0] rd_exp;
  int          rd_cyc;

  denise_top uut (
    .clk    (clk),
    .reset  (reset),
    .rga    (rga),
    .db_in  (db_in),
    .db_out (db_out),
    .db_oen (db_oen),
    .red    (red),
    .green  (green),
    .blue   (blue),
    .sol    (sol)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Pixel of sprite s at position h, {B bit, A bit}, MSB first
  function automatic logic [1:0] spr_pixel(input int s, input int h);
    int i;
    spr_pixel = 2'b00;
    if (m_armed[s] && h >= m_start[s] && h < m_start[s] + 16) begin
      i = h - m_start[s];
      spr_pixel = {m_db[s][15-i], m_da[s][15-i]};
    end
  endfunction

  function automatic logic [11:0] ref_pixel(input int h);
    logic [1:0] p;
    int         idx;
    bit         found;
    idx   = 0;
    found = 0;
    // Lowest pair first, even sprite over odd
    for (int k = 0; k < `NUM_PAIRS; k++) begin
      if (!found) begin
        p = spr_pixel(2 * k, h);
        if (p == 2'b00) begin
          p = spr_pixel(2 * k + 1, h);
        end
        if (p != 2'b00) begin
          idx   = 16 + 4 * k + p;
          found = 1;
        end
      end
    end
    return m_clut[idx];
  endfunction

  // Expected CLXDAT after one full line of the current setup
  function automatic logic [15:0] ref_clx();
    logic [3:0]  g;
    logic [15:0] r;
    r = '0;
    for (int h = 0; h < LINE; h++) begin
      for (int k = 0; k < `NUM_PAIRS; k++) begin
        g[k] = (spr_pixel(2 * k, h) != 2'b00) ||
               ((spr_pixel(2 * k + 1, h) != 2'b00) && m_ensp[k]);
      end
      r[9]  = r[9]  | (g[0] & g[1]);
      r[10] = r[10] | (g[0] & g[2]);
      r[11] = r[11] | (g[0] & g[3]);
      r[12] = r[12] | (g[1] & g[2]);
      r[13] = r[13] | (g[1] & g[3]);
      r[14] = r[14] | (g[2] & g[3]);
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus tasks, entered 1 ns after a rising edge
  ////////////////////////////////////////////////////////////

  task automatic bus_access(input logic [7:0] addr, input logic [15:0] data);
    rga   = addr;
    db_in = data;
    @(posedge clk);
    #1;
    rga   = RGA_IDLE;
    db_in = '0;
  endtask

  // Data and enable due at the third edge from now
  task automatic read_reg(input logic [7:0] addr, input logic [15:0] exp);
    exp_rd_q.push_back(exp);
    exp_cyc_q.push_back(cycle_cnt + 3);
    bus_access(addr, 16'h0000);
  endtask

  task automatic write_color(input int idx, input logic [15:0] val);
    m_clut[idx] = val[11:0];
    bus_access(RGA_COLOR + 8'(idx), val);
  endtask

  task automatic set_ensp(input logic [3:0] val);
    m_ensp = val;
    bus_access(RGA_CLXCON, {val, 12'h000});
  endtask

  // POS, CTL, DATB, then DATA which arms
  task automatic write_sprite(input int s, input logic [8:0] start,
                              input logic [15:0] da, input logic [15:0] db);
    m_start[s] = start;
    m_da[s]    = da;
    m_db[s]    = db;
    m_armed[s] = 1'b1;
    bus_access(RGA_SPR + 8'(4 * s), {8'h00, start[8:1]});
    bus_access(RGA_SPR + 8'(4 * s + 1), {15'h0000, start[0]});
    bus_access(RGA_SPR + 8'(4 * s + 3), db);
    bus_access(RGA_SPR + 8'(4 * s + 2), da);
  endtask

  task automatic disable_sprite(input int s);
    m_armed[s] = 1'b0;
    bus_access(RGA_SPR + 8'(4 * s + 1), {15'h0000, m_start[s][0]});
  endtask

  task automatic wait_sol();
    do begin
      @(negedge clk);
    end while (sol !== 1'b1);
  endtask

  // From a sol cycle to the sprite-free gap at hpos 497
  task automatic to_gap();
    repeat (GAP_DELAY) @(posedge clk);
    #1;
  endtask

  // Let the configured line pass, then collect its collisions
  task automatic end_line();
    wait_sol();
    to_gap();
    read_reg(RGA_CLXDAT, ref_clx());
  endtask

  ////////////////////////////////////////////////////////////
  // Compare processes
  ////////////////////////////////////////////////////////////

  always begin
    @(negedge clk);
    if (check_en && sol === 1'b1) begin
      busy = 1;
      if (last_sol >= 0) begin
        check_cnt++;
        assert (cycle_cnt - last_sol == LINE) else begin
          err_cnt++;
          $display("Fail at %0t: line period %0d cycles", $time, cycle_cnt - last_sol);
        end
      end
      last_sol = cycle_cnt;
      for (int h = 32; h < LINE; h++) begin
        exp_rgb[h] = ref_pixel(h);
      end
      // Position h is on the outputs h-32 cycles after sol
      for (int h = 32; h < LINE; h++) begin
        if (h > 32) begin
          @(negedge clk);
        end
        check_cnt++;
        assert ({red, green, blue} === exp_rgb[h]) else begin
          err_cnt++;
          $display("Fail at %0t: position %0d rgb %h, expected %h",
                   $time, h, {red, green, blue}, exp_rgb[h]);
        end
      end
      busy = 0;
    end
  end

  always @(negedge clk) begin
    if (!reset && db_oen === 1'b1) begin
      check_cnt++;
      assert (exp_rd_q.size() != 0) else begin
        err_cnt++;
        $display("Error at %0t: db_oen high with no read pending", $time);
      end
      if (exp_rd_q.size() != 0) begin
        rd_exp = exp_rd_q.pop_front();
        rd_cyc = exp_cyc_q.pop_front();
        check_cnt++;
        assert (db_out === rd_exp && cycle_cnt == rd_cyc) else begin
          err_cnt++;
          $display("Fail at %0t: read %h at cycle %0d, expected %h at cycle %0d",
                   $time, db_out, cycle_cnt, rd_exp, rd_cyc);
        end
      end
    end
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    seed  = 32'h8b8a_6228;
    reset = 1'b1;
    rga   = RGA_IDLE;
    db_in = '0;
    m_ensp = '0;
    for (int s = 0; s < `NUM_SPRITES; s++) begin
      m_start[s] = '0;
      m_armed[s] = 1'b0;
      m_da[s]    = '0;
      m_db[s]    = '0;
    end
    @(posedge clk);
    @(negedge clk);
    check_cnt++;
    assert (db_oen === 1'b0 && sol === 1'b0 && {red, green, blue} === 12'h000) else begin
      err_cnt++;
      $display("Fail at %0t: outputs not cleared by reset", $time);
    end
    @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < `CLUT_DEPTH; i++) begin
      write_color(i, $random(seed));
    end

    // STRHOR before edge n gives sol after edge n+36
    wait_sol();
    @(posedge clk);
    #1;
    bus_access(RGA_STRHOR, 16'h0000);
    repeat (35) @(posedge clk);
    @(negedge clk);
    check_cnt++;
    assert (sol === 1'b0) else begin
      err_cnt++;
      $display("Fail at %0t: sol early after STRHOR", $time);
    end
    @(negedge clk);
    check_cnt++;
    assert (sol === 1'b1) else begin
      err_cnt++;
      $display("Fail at %0t: sol missing 36 edges after STRHOR", $time);
    end
    to_gap();
    read_reg(RGA_CLXDAT, 16'h0000);
    set_ensp(4'h0);
    check_en = 1;

    // Plain line
    end_line();

    // Each sprite alone, previous one removed by SPRCTL
    for (int s = 0; s < `NUM_SPRITES; s++) begin
      if (s > 0) begin
        disable_sprite(s - 1);
      end
      write_sprite(s, 9'(40 + 55 * s), $random(seed), $random(seed));
      end_line();
    end
    disable_sprite(`NUM_SPRITES - 1);

    // Overlaps across and inside pairs, odd sprites not in groups
    set_ensp(4'h0);
    write_sprite(0, 9'd100, 16'hF0F0, 16'hFF00);
    write_sprite(1, 9'd104, 16'hFFFF, 16'h0F0F);
    write_sprite(3, 9'd110, 16'hAAAA, 16'h5555);
    write_sprite(4, 9'd300, 16'h0FF0, 16'h3C3C);
    write_sprite(5, 9'd296, 16'hFFFF, 16'hFFFF);
    write_sprite(6, 9'd305, 16'h8001, 16'h7FFE);
    end_line();

    // Same with all odd sprites enabled
    set_ensp(4'hF);
    write_sprite(2, 9'd102, 16'h3333, 16'hCCCC);
    end_line();
    read_reg(RGA_CLXDAT, 16'h0000);

    // Random lines
    for (int l = 0; l < 10; l++) begin
      for (int i = 16; i < `CLUT_DEPTH; i++) begin
        write_color(i, $random(seed));
      end
      set_ensp($random(seed));
      for (int s = 0; s < `NUM_SPRITES; s++) begin
        write_sprite(s, 9'(40 + {$random(seed)} % 441), $random(seed), $random(seed));
      end
      end_line();
    end
    read_reg(RGA_CLXDAT, 16'h0000);
    read_reg(RGA_ID, `DENISE_ID);

    check_en = 0;
    wait (busy == 0);
    repeat (4) @(posedge clk);
    check_cnt++;
    assert (exp_rd_q.size() == 0) else begin
      err_cnt++;
      $display("Error: %0d reads returned no data", exp_rd_q.size());
    end
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
logic/denise_pkg.sv
logic/reg_decoder.sv
logic/beam_counter.sv
logic/sprite_channel.sv
logic/sprite_priority.sv
logic/register_readback.sv
logic/color_output.sv
logic/denise_top.sv
dv/denise_tb.sv
